// File: branch_predictor.f
+incdir+include
design/bp_pkg.sv
design/local_predictor.sv
design/gshare_predictor.sv
design/tournament_chooser.sv
design/branch_target_buffer.sv
design/branch_predictor.sv
tests/branch_predictor_tb.sv

// File: design/bp_pkg.sv
package bp_pkg;

    // ----------------------------------------
    // widths and table sizes
    // ----------------------------------------
    localparam int xlen = 32;
    localparam int pc_offset = 2;            // rv32i fetch addresses are word aligned.
    localparam int lht_idx_bits = 5;
    localparam int lhist_bits = 2;
    localparam int ghist_bits = 6;
    localparam int chooser_idx_bits = 6;
    localparam int btb_idx_bits = 4;
    localparam int btb_tag_bits = xlen - btb_idx_bits - pc_offset;

    localparam int lht_entries = 2 ** lht_idx_bits;
    localparam int lpht_entries = 2 ** lhist_bits;
    localparam int gpht_entries = 2 ** ghist_bits;
    localparam int chooser_entries = 2 ** chooser_idx_bits;
    localparam int btb_entries = 2 ** btb_idx_bits;

    typedef logic [xlen-1:0] word_t;

    // ----------------------------------------
    // two-bit saturating counter
    // ----------------------------------------
    typedef enum logic [1:0] {
        strong_nt,
        weak_nt,
        weak_t,
        strong_t
    } counter_t;

    localparam counter_t counter_reset = weak_nt;

    function automatic counter_t counter_next(counter_t state, logic taken);
        counter_t next_state;
        next_state = state;
        unique case (state)
            strong_nt: next_state = taken ? weak_nt : strong_nt;
            weak_nt:   next_state = taken ? weak_t : strong_nt;
            weak_t:    next_state = taken ? strong_t : weak_nt;
            strong_t:  next_state = taken ? strong_t : weak_t;
            default:   next_state = counter_reset;
        endcase
        return next_state;
    endfunction

    function automatic logic counter_taken(counter_t state);
        return (state == weak_t) || (state == strong_t);
    endfunction

endpackage

// File: design/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor (
    input  logic          clk,
    input  logic          rst,
    input  logic          update,
    input  logic          br_en,
    input  bp_pkg::word_t raddr,
    input  bp_pkg::word_t waddr,
    input  bp_pkg::word_t wtarget,
    output logic          br_take,
    output logic          btb_hit,
    output logic          mispred,
    output bp_pkg::word_t target
);

    logic local_take;
    logic local_miss;
    logic global_take;
    logic global_miss;

    // ----------------------------------------
    // direction predictors
    // ----------------------------------------
    local_predictor local_predictor_inst (
        .clk        (clk),
        .rst        (rst),
        .update     (update),
        .br_en      (br_en),
        .raddr      (raddr),
        .waddr      (waddr),
        .local_take (local_take),
        .local_miss (local_miss)
    );

    gshare_predictor gshare_predictor_inst (
        .clk         (clk),
        .rst         (rst),
        .update      (update),
        .br_en       (br_en),
        .raddr       (raddr),
        .waddr       (waddr),
        .global_take (global_take),
        .global_miss (global_miss)
    );

    tournament_chooser tournament_chooser_inst (
        .clk         (clk),
        .rst         (rst),
        .update      (update),
        .br_en       (br_en),
        .local_take  (local_take),
        .global_take (global_take),
        .local_miss  (local_miss),
        .global_miss (global_miss),
        .raddr       (raddr),
        .waddr       (waddr),
        .br_take     (br_take),
        .mispred     (mispred)
    );

    // target lookup runs beside the direction path.
    branch_target_buffer branch_target_buffer_inst (
        .clk     (clk),
        .rst     (rst),
        .update  (update),
        .br_en   (br_en),
        .raddr   (raddr),
        .waddr   (waddr),
        .wtarget (wtarget),
        .target  (target),
        .btb_hit (btb_hit)
    );

endmodule

// File: design/branch_target_buffer.sv
`timescale 1ns/1ps

module branch_target_buffer (
    input  logic          clk,
    input  logic          rst,
    input  logic          update,
    input  logic          br_en,
    input  bp_pkg::word_t raddr,
    input  bp_pkg::word_t waddr,
    input  bp_pkg::word_t wtarget,
    output bp_pkg::word_t target,
    output logic          btb_hit
);

    logic valid [bp_pkg::btb_entries];
    logic [bp_pkg::btb_tag_bits-1:0] tags [bp_pkg::btb_entries];
    bp_pkg::word_t targets [bp_pkg::btb_entries];

    logic [bp_pkg::btb_idx_bits-1:0] r_idx;
    logic [bp_pkg::btb_idx_bits-1:0] w_idx;
    logic [bp_pkg::btb_tag_bits-1:0] r_tag;
    logic [bp_pkg::btb_tag_bits-1:0] w_tag;
    logic write_en;
    logic bypass;

    // ----------------------------------------
    // address split
    // ----------------------------------------
    assign r_idx = raddr[bp_pkg::btb_idx_bits+bp_pkg::pc_offset-1:bp_pkg::pc_offset];
    assign w_idx = waddr[bp_pkg::btb_idx_bits+bp_pkg::pc_offset-1:bp_pkg::pc_offset];
    assign r_tag = raddr[bp_pkg::xlen-1:bp_pkg::xlen-bp_pkg::btb_tag_bits];
    assign w_tag = waddr[bp_pkg::xlen-1:bp_pkg::xlen-bp_pkg::btb_tag_bits];

    assign write_en = update && br_en;   // only taken branches allocate.
    assign bypass = write_en && (w_idx == r_idx);

    // ----------------------------------------
    // lookup
    // ----------------------------------------
    always_comb begin
        btb_hit = 1'b0;
        target = '0;
        if (bypass) begin
            // the entry is being replaced, so only the new tag can match.
            btb_hit = (w_tag == r_tag);
            target = btb_hit ? wtarget : '0;
        end else if (valid[r_idx] && (tags[r_idx] == r_tag)) begin
            btb_hit = 1'b1;
            target = targets[r_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < bp_pkg::btb_entries; i++) begin
                valid[i] <= 1'b0;
            end
        end else if (write_en) begin
            valid[w_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write_en) begin
            tags[w_idx] <= w_tag;
            targets[w_idx] <= wtarget;
        end
    end

endmodule

// File: design/gshare_predictor.sv
`timescale 1ns/1ps

module gshare_predictor (
    input  logic          clk,
    input  logic          rst,
    input  logic          update,
    input  logic          br_en,
    input  bp_pkg::word_t raddr,
    input  bp_pkg::word_t waddr,
    output logic          global_take,
    output logic          global_miss
);

    bp_pkg::counter_t pht [bp_pkg::gpht_entries];
    logic [bp_pkg::ghist_bits-1:0] ghr;   // newest outcome in bit 0.

    logic [bp_pkg::ghist_bits-1:0] r_idx;
    logic [bp_pkg::ghist_bits-1:0] w_idx;
    bp_pkg::counter_t r_state;
    bp_pkg::counter_t w_state;
    bp_pkg::counter_t state_in;

    // ----------------------------------------
    // index hashing
    // ----------------------------------------
    // Both ports hash with the history as it stands before this cycle's
    // update. The shift only lands at the clock edge.
    assign r_idx = ghr ^ raddr[bp_pkg::ghist_bits+bp_pkg::pc_offset-1:bp_pkg::pc_offset];
    assign w_idx = ghr ^ waddr[bp_pkg::ghist_bits+bp_pkg::pc_offset-1:bp_pkg::pc_offset];

    // ----------------------------------------
    // counters
    // ----------------------------------------
    assign w_state = pht[w_idx];
    assign state_in = bp_pkg::counter_next(w_state, br_en);
    assign r_state = (update && (w_idx == r_idx)) ? state_in : pht[r_idx];

    assign global_take = bp_pkg::counter_taken(r_state);
    assign global_miss = update && (bp_pkg::counter_taken(w_state) != br_en);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < bp_pkg::gpht_entries; i++) begin
                pht[i] <= bp_pkg::counter_reset;
            end
            ghr <= '0;
        end else if (update) begin
            pht[w_idx] <= state_in;
            ghr <= {ghr[bp_pkg::ghist_bits-2:0], br_en};
        end
    end

endmodule

// File: design/local_predictor.sv
`timescale 1ns/1ps

module local_predictor (
    input  logic          clk,
    input  logic          rst,
    input  logic          update,
    input  logic          br_en,
    input  bp_pkg::word_t raddr,
    input  bp_pkg::word_t waddr,
    output logic          local_take,
    output logic          local_miss
);

    // per-branch history table and the counter table it indexes.
    logic [bp_pkg::lhist_bits-1:0] lht [bp_pkg::lht_entries];
    bp_pkg::counter_t pht [bp_pkg::lpht_entries];

    logic [bp_pkg::lht_idx_bits-1:0] r_idx;
    logic [bp_pkg::lht_idx_bits-1:0] w_idx;
    logic [bp_pkg::lhist_bits-1:0] r_hist;
    logic [bp_pkg::lhist_bits-1:0] w_hist;
    logic [bp_pkg::lhist_bits-1:0] hist_in;
    bp_pkg::counter_t r_state;
    bp_pkg::counter_t w_state;
    bp_pkg::counter_t state_in;

    // ----------------------------------------
    // write side
    // ----------------------------------------
    assign w_idx = waddr[bp_pkg::lht_idx_bits+bp_pkg::pc_offset-1:bp_pkg::pc_offset];
    assign w_hist = lht[w_idx];
    assign hist_in = {w_hist[bp_pkg::lhist_bits-2:0], br_en};  // newest outcome in bit 0.
    assign w_state = pht[w_hist];
    assign state_in = bp_pkg::counter_next(w_state, br_en);

    assign local_miss = update && (bp_pkg::counter_taken(w_state) != br_en);

    // ----------------------------------------
    // read side with bypass
    // ----------------------------------------
    assign r_idx = raddr[bp_pkg::lht_idx_bits+bp_pkg::pc_offset-1:bp_pkg::pc_offset];

    // The history is bypassed first, so the counter lookup below already
    // sees the shifted history when both ports hit the same entry.
    assign r_hist = (update && (w_idx == r_idx)) ? hist_in : lht[r_idx];
    assign r_state = (update && (w_hist == r_hist)) ? state_in : pht[r_hist];

    assign local_take = bp_pkg::counter_taken(r_state);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < bp_pkg::lpht_entries; i++) begin
                pht[i] <= bp_pkg::counter_reset;
            end
            for (int j = 0; j < bp_pkg::lht_entries; j++) begin
                lht[j] <= '0;
            end
        end else if (update) begin
            pht[w_hist] <= state_in;
            lht[w_idx] <= hist_in;
        end
    end

    // a miss only describes the branch being resolved right now.
    local_miss_needs_update: assert property (
        @(posedge clk) disable iff (rst) local_miss |-> update
    ) else $error("local_miss high without update");

endmodule

// File: design/tournament_chooser.sv
`timescale 1ns/1ps

module tournament_chooser (
    input  logic          clk,
    input  logic          rst,
    input  logic          update,
    input  logic          br_en,
    input  logic          local_take,
    input  logic          global_take,
    input  logic          local_miss,
    input  logic          global_miss,
    input  bp_pkg::word_t raddr,
    input  bp_pkg::word_t waddr,
    output logic          br_take,
    output logic          mispred
);

    // a taken chooser state means the global predictor is preferred.
    bp_pkg::counter_t choice [bp_pkg::chooser_entries];

    logic [bp_pkg::chooser_idx_bits-1:0] r_idx;
    logic [bp_pkg::chooser_idx_bits-1:0] w_idx;
    logic train;
    bp_pkg::counter_t r_state;
    bp_pkg::counter_t w_state;
    bp_pkg::counter_t state_in;

    assign r_idx = raddr[bp_pkg::chooser_idx_bits+bp_pkg::pc_offset-1:bp_pkg::pc_offset];
    assign w_idx = waddr[bp_pkg::chooser_idx_bits+bp_pkg::pc_offset-1:bp_pkg::pc_offset];

    // ----------------------------------------
    // training
    // ----------------------------------------
    // Only a disagreement tells us which side is better. A local miss
    // pushes toward global, a global miss pushes toward local.
    assign train = update && (local_miss != global_miss);
    assign w_state = choice[w_idx];
    assign state_in = train ? bp_pkg::counter_next(w_state, local_miss) : w_state;

    assign mispred = update && (bp_pkg::counter_taken(w_state) ? global_miss : local_miss);

    // ----------------------------------------
    // selection
    // ----------------------------------------
    assign r_state = (update && (w_idx == r_idx)) ? state_in : choice[r_idx];
    assign br_take = bp_pkg::counter_taken(r_state) ? global_take : local_take;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < bp_pkg::chooser_entries; i++) begin
                choice[i] <= bp_pkg::counter_reset;
            end
        end else if (train) begin
            choice[w_idx] <= state_in;
        end
    end

    mispred_needs_update: assert property (
        @(posedge clk) disable iff (rst) mispred |-> update
    ) else $error("mispred high without update");

    // the execute stage must hand over a resolved outcome.
    outcome_known: assert property (
        @(posedge clk) disable iff (rst) update |-> !$isunknown(br_en)
    ) else $error("br_en unknown on update");

endmodule

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and search the log for the result.
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --top-module branch_predictor_tb \
    -f branch_predictor.f > build.log 2>&1 \
    && ./obj_dir/Vbranch_predictor_tb > sim.log 2>&1 \
    || { echo "build or run error, see build.log and sim.log"; exit 1; }
grep -q "^Simulation passed$" sim.log \
    && echo "result: pass" \
    || { echo "result: fail, see sim.log"; exit 1; }

// File: include/bp_tb_model.svh
`ifndef BP_TB_MODEL_SVH
`define BP_TB_MODEL_SVH

// ----------------------------------------
// model state that mirrors every DUT table
// ----------------------------------------
logic [bp_pkg::lhist_bits-1:0] m_lht [bp_pkg::lht_entries];
bp_pkg::counter_t m_lpht [bp_pkg::lpht_entries];
bp_pkg::counter_t m_gpht [bp_pkg::gpht_entries];
bp_pkg::counter_t m_chooser [bp_pkg::chooser_entries];
logic [bp_pkg::ghist_bits-1:0] m_ghr;
logic m_btb_valid [bp_pkg::btb_entries];
logic [bp_pkg::btb_tag_bits-1:0] m_btb_tag [bp_pkg::btb_entries];
bp_pkg::word_t m_btb_target [bp_pkg::btb_entries];
int error_count;

// one saturating step along the state order strong_nt .. strong_t.
function automatic bp_pkg::counter_t step_counter(bp_pkg::counter_t state, logic taken);
    logic [1:0] level;
    level = state;
    if (taken && (level != 2'b11)) begin
        level = level + 2'd1;
    end else if (!taken && (level != 2'b00)) begin
        level = level - 2'd1;
    end
    return bp_pkg::counter_t'(level);
endfunction

function automatic logic predicts_taken(bp_pkg::counter_t state);
    return state inside {bp_pkg::weak_t, bp_pkg::strong_t};
endfunction

function automatic void model_reset();
    foreach (m_lht[i]) m_lht[i] = '0;
    foreach (m_lpht[i]) m_lpht[i] = bp_pkg::weak_nt;
    foreach (m_gpht[i]) m_gpht[i] = bp_pkg::weak_nt;
    foreach (m_chooser[i]) m_chooser[i] = bp_pkg::weak_nt;
    foreach (m_btb_valid[i]) m_btb_valid[i] = 1'b0;
    m_ghr = '0;
endfunction

// the expected mispred is read from the tables before model_update runs.
function automatic logic model_mispred(bp_pkg::word_t addr, logic taken);
    logic lmiss;
    logic gmiss;
    lmiss = predicts_taken(m_lpht[m_lht[addr[6:2]]]) != taken;
    gmiss = predicts_taken(m_gpht[m_ghr ^ addr[7:2]]) != taken;
    return predicts_taken(m_chooser[addr[7:2]]) ? gmiss : lmiss;
endfunction

function automatic void model_update(bp_pkg::word_t addr, logic taken, bp_pkg::word_t tgt);
    logic lmiss;
    logic gmiss;
    lmiss = predicts_taken(m_lpht[m_lht[addr[6:2]]]) != taken;
    gmiss = predicts_taken(m_gpht[m_ghr ^ addr[7:2]]) != taken;
    if (lmiss != gmiss)
        m_chooser[addr[7:2]] = step_counter(m_chooser[addr[7:2]], lmiss);
    m_lpht[m_lht[addr[6:2]]] = step_counter(m_lpht[m_lht[addr[6:2]]], taken);
    m_lht[addr[6:2]] = {m_lht[addr[6:2]][0], taken};
    m_gpht[m_ghr ^ addr[7:2]] = step_counter(m_gpht[m_ghr ^ addr[7:2]], taken);
    m_ghr = {m_ghr[bp_pkg::ghist_bits-2:0], taken};
    if (taken) begin
        m_btb_valid[addr[5:2]] = 1'b1;
        m_btb_tag[addr[5:2]] = addr[31:6];
        m_btb_target[addr[5:2]] = tgt;
    end
endfunction

// In an update cycle, call model_update first and pass the old history here.
function automatic void model_read(bp_pkg::word_t addr, logic [bp_pkg::ghist_bits-1:0] ghr,
                                   output logic take, output bp_pkg::word_t tgt,
                                   output logic hit);
    logic ltake;
    logic gtake;
    ltake = predicts_taken(m_lpht[m_lht[addr[6:2]]]);
    gtake = predicts_taken(m_gpht[ghr ^ addr[7:2]]);
    take = predicts_taken(m_chooser[addr[7:2]]) ? gtake : ltake;
    hit = m_btb_valid[addr[5:2]] && (m_btb_tag[addr[5:2]] == addr[31:6]);
    tgt = hit ? m_btb_target[addr[5:2]] : '0;
endfunction

task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
        error_count++;
        $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
endtask

task automatic check_word(string name, bp_pkg::word_t got, bp_pkg::word_t exp);
    if (got !== exp) begin
        error_count++;
        $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
endtask

`endif

// File: tests/branch_predictor_tb.sv
`timescale 1ns/1ps

module branch_predictor_tb;

    logic clk = 1'b0;
    logic rst;
    logic update;
    logic br_en;
    bp_pkg::word_t raddr;
    bp_pkg::word_t waddr;
    bp_pkg::word_t wtarget;
    logic br_take;
    logic btb_hit;
    logic mispred;
    bp_pkg::word_t target;
    int timeout_count;

    `include "bp_tb_model.svh"

    always #2 clk = ~clk;   // 4 ns period.

    branch_predictor branch_predictor_inst (
        .clk     (clk),
        .rst     (rst),
        .update  (update),
        .br_en   (br_en),
        .raddr   (raddr),
        .waddr   (waddr),
        .wtarget (wtarget),
        .br_take (br_take),
        .btb_hit (btb_hit),
        .mispred (mispred),
        .target  (target)
    );

    // ----------------------------------------
    // cycle driver and reference check
    // ----------------------------------------
    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        update <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        model_reset();
    endtask

    // random word aligned pc with a chosen btb index.
    function automatic bp_pkg::word_t make_pc(logic [bp_pkg::btb_idx_bits-1:0] idx);
        bp_pkg::word_t rnd;
        rnd = $urandom();
        return {rnd[bp_pkg::xlen-1:bp_pkg::btb_idx_bits+bp_pkg::pc_offset], idx, 2'b00};
    endfunction

    task automatic run_cycle(input logic upd, input bp_pkg::word_t wa, input logic taken,
                             input bp_pkg::word_t wtgt, input bp_pkg::word_t ra);
        logic [bp_pkg::ghist_bits-1:0] old_ghr;
        logic exp_mispred;
        logic exp_take;
        logic exp_hit;
        bp_pkg::word_t exp_target;
        @(posedge clk);
        update <= upd;
        waddr <= wa;
        br_en <= taken;
        wtarget <= wtgt;
        raddr <= ra;
        @(negedge clk);
        old_ghr = m_ghr;    // the gshare read still hashes with this history.
        exp_mispred = 1'b0;
        if (upd) begin
            exp_mispred = model_mispred(wa, taken);
            model_update(wa, taken, wtgt);
        end
        model_read(ra, old_ghr, exp_take, exp_target, exp_hit);
        check_bit("br_take", br_take, exp_take);
        check_bit("mispred", mispred, exp_mispred);
        check_bit("btb_hit", btb_hit, exp_hit);
        check_word("target", target, exp_target);
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic test_reset();
        apply_reset();
        repeat (16) begin
            run_cycle(1'b0, '0, 1'b0, '0, $urandom());
            check_bit("br_take", br_take, 1'b0);
            check_bit("btb_hit", btb_hit, 1'b0);
            check_bit("mispred", mispred, 1'b0);
        end
    endtask

    task automatic test_always_taken();
        bp_pkg::word_t pc;
        bp_pkg::word_t tgt;
        int n;
        apply_reset();
        pc = make_pc(4'h3);
        tgt = pc + 32'h0000_0100;
        n = 0;
        run_cycle(1'b1, pc, 1'b1, tgt, pc);
        while (!br_take && n < 32) begin
            run_cycle(1'b1, pc, 1'b1, tgt, pc);
            n++;
        end
        if (!br_take) begin
            timeout_count++;
            $display("timeout: always taken branch still predicted not taken after %0d updates", n);
        end
        repeat (12) begin
            run_cycle(1'b1, pc, 1'b1, tgt, pc);
            check_bit("br_take", br_take, 1'b1);
            check_word("target", target, tgt);
        end
    endtask

    task automatic test_alternating();
        bp_pkg::word_t pc;
        logic outcome;
        int quiet;
        int n;
        apply_reset();
        pc = make_pc(4'h2);
        outcome = 1'b1;
        quiet = 0;
        n = 0;
        while (quiet < 8 && n < 48) begin
            run_cycle(1'b1, pc, outcome, pc + 32'h40, pc);
            quiet = mispred ? 0 : quiet + 1;
            outcome = !outcome;
            n++;
        end
        if (quiet < 8) begin
            timeout_count++;
            $display("timeout: alternating branch still mispredicted after %0d updates", n);
        end
        repeat (8) begin
            run_cycle(1'b1, pc, outcome, pc + 32'h40, pc);
            check_bit("mispred", mispred, 1'b0);
            outcome = !outcome;
        end
        // the local side never lost to gshare here, so the chooser stays local.
        check_bit("chooser_pref",
                  predicts_taken(branch_predictor_inst.tournament_chooser_inst.choice[pc[7:2]]),
                  1'b0);
    endtask

    task automatic test_btb();
        bp_pkg::word_t pcs [4];
        bp_pkg::word_t tgts [4];
        bp_pkg::word_t alias_pc;
        bp_pkg::word_t cold_pc;
        apply_reset();
        for (int i = 0; i < 4; i++) begin
            pcs[i] = make_pc(4'(i));
            tgts[i] = $urandom() & 32'hffff_fffc;
            run_cycle(1'b1, pcs[i], 1'b1, tgts[i], '0);
        end
        for (int i = 0; i < 4; i++) begin
            run_cycle(1'b0, '0, 1'b0, '0, pcs[i]);
            check_bit("btb_hit", btb_hit, 1'b1);
            check_word("target", target, tgts[i]);
            alias_pc = pcs[i] ^ 32'h8000_0000;  // same index, other tag.
            run_cycle(1'b0, '0, 1'b0, '0, alias_pc);
            check_bit("btb_hit", btb_hit, 1'b0);
            check_word("target", target, '0);
        end
        cold_pc = make_pc(4'h9);
        run_cycle(1'b1, cold_pc, 1'b0, 32'h0000_4000, '0);
        run_cycle(1'b0, '0, 1'b0, '0, cold_pc);
        check_bit("btb_hit", btb_hit, 1'b0);
    endtask

    task automatic test_bypass();
        bp_pkg::word_t pc;
        bp_pkg::word_t other_pc;
        bp_pkg::word_t tgt;
        apply_reset();
        pc = make_pc(4'h5);
        tgt = $urandom() & 32'hffff_fffc;
        // the table is empty, so a hit can only come from the write port.
        run_cycle(1'b1, pc, 1'b1, tgt, pc);
        check_bit("btb_hit", btb_hit, 1'b1);
        check_word("target", target, tgt);
        repeat (3) run_cycle(1'b1, pc, 1'b1, tgt, pc);
        check_bit("br_take", br_take, 1'b1);
        other_pc = pc ^ 32'h4000_0000;
        run_cycle(1'b1, other_pc, 1'b1, tgt + 32'h10, pc);
        check_bit("btb_hit", btb_hit, 1'b0);
        check_word("target", target, '0);
        run_cycle(1'b1, other_pc, 1'b1, tgt + 32'h20, other_pc);
        check_word("target", target, tgt + 32'h20);
    endtask

    task automatic test_random_stream();
        bp_pkg::word_t pcs [8];
        logic [2:0] k;
        logic [2:0] r;
        logic [2:0] rd;
        apply_reset();
        for (int i = 0; i < 8; i++) begin
            pcs[i] = make_pc(4'($urandom()));
        end
        repeat (300) begin
            k = 3'($urandom());
            r = 3'($urandom());
            rd = 3'($urandom());
            // pc k is taken about k times in 8.
            run_cycle(1'b1, pcs[k], r < k, $urandom() & 32'hffff_fffc, pcs[rd]);
        end
    endtask

    initial begin
        rst <= 1'b1;
        update <= 1'b0;
        br_en <= 1'b0;
        raddr <= '0;
        waddr <= '0;
        wtarget <= '0;
        error_count = 0;
        timeout_count = 0;
        void'($urandom(32'h08ca_9bed));
        model_reset();
        test_reset();
        test_always_taken();
        test_alternating();
        test_btb();
        test_bypass();
        test_random_stream();
        $display("errors: %0d check failures, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
